//--- sources.f
core_pkg.sv
opcode_decoder.sv
cycle_sequencer.sv
program_counter.sv
register_file.sv
alu.sv
core_top.sv
tb_core.sv

//--- Bender.yml
package:
  name: core8

sources:
  - core_pkg.sv
  - opcode_decoder.sv
  - cycle_sequencer.sv
  - program_counter.sv
  - register_file.sv
  - alu.sv
  - core_top.sv
  - target: simulation
    files:
      - tb_core.sv

//--- tb_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core;

	localparam int total_instr = 46;
	localparam int limit_ns    = total_instr * 20 + 5 * 17 * 10 + 1000;   // Runs plus resets

	logic                          ALU_CLK;
	logic                          hclk;
	logic [7:0]                    io_din;
	logic [15:0]                   opcode;
	logic [core_pkg::pc_w-1:0]     pc;
	core_pkg::io_bus_t             io;
	logic [7:0]                    sreg;

	logic [15:0] rom [4096];
	int          plen;
	int          seed;
	int          errors;
	int          checks;
	int          tests;
	logic [5:0]  wr_addr_q [$];
	logic [7:0]  wr_data_q [$];
	int          rd_cnt;
	logic [5:0]  rd_addr;
	logic        wr_prev;
	logic        rd_prev;

	core_top core_top_i (
		.ALU_CLK  (ALU_CLK),
		.hclk     (hclk),
		.i_opcode (opcode),
		.i_io_din (io_din),
		.o_pc     (pc),
		.o_io     (io),
		.o_sreg   (sreg)
	);

	assign opcode = rom[pc];   // Combinational ROM

	initial
	begin
		ALU_CLK = 1'b0;
		forever #5 ALU_CLK = ~ALU_CLK;
	end

	// IO device samples the strobes at the edge that ends execute
	always @(posedge ALU_CLK)
	begin
		if (io.wr)
		begin
			wr_addr_q.push_back(io.addr);
			wr_data_q.push_back(io.dout);
		end
		if (io.rd)
		begin
			rd_cnt  = rd_cnt + 1;
			rd_addr = io.addr;
		end
		if ((io.wr && wr_prev) || (io.rd && rd_prev))
		begin
			errors++;
			$display("An IO strobe stayed high for more than one cycle");
		end
		wr_prev = io.wr;
		rd_prev = io.rd;
	end

	function automatic logic [15:0] ldi_word(input logic [3:0] d, input logic [7:0] k);
		return {4'b1110, k[7:4], d, k[3:0]};
	endfunction

	function automatic logic [15:0] pair_word(input logic [5:0] op, input logic [4:0] d,
		input logic [4:0] r);
		return {op, r[4], d, r[3:0]};
	endfunction

	function automatic logic [15:0] single_word(input logic [4:0] d, input logic [3:0] op);
		return {7'b1001010, d, op};
	endfunction

	function automatic logic [15:0] port_word(input logic out, input logic [5:0] a,
		input logic [4:0] r);
		return {4'b1011, out, a[5:4], r, a[3:0]};
	endfunction

	function automatic logic [15:0] flag_word(input logic clr, input logic [2:0] s);
		return {8'b1001_0100, clr, s, 4'b1000};
	endfunction

	function automatic logic [15:0] branch_word(input logic brbc, input logic [6:0] k,
		input logic [2:0] s);
		return {5'b11110, brbc, k, s};
	endfunction

	function automatic logic [11:0] next_pc(input logic [11:0] p, input logic [11:0] off);
		return p + 12'd1 + off;   // Wraps at 4096
	endfunction

	function automatic logic [7:0] nzvs(input logic [7:0] s, input logic [7:0] r, input logic v);
		logic [7:0] f;
		f = s;
		f[core_pkg::sreg_n] = r[7];
		f[core_pkg::sreg_z] = (r == 8'h00);
		f[core_pkg::sreg_v] = v;
		f[core_pkg::sreg_s] = r[7] ^ v;
		return f;
	endfunction

	// Result in the low byte, flags in the high byte
	function automatic logic [15:0] add_model(input logic [7:0] a, input logic [7:0] b,
		input logic cin, input logic [7:0] s);
		logic [8:0] sum;
		logic [7:0] f;
		sum = a + b + cin;
		f = nzvs(s, sum[7:0], (a[7] == b[7]) && (sum[7] != a[7]));
		f[core_pkg::sreg_c] = sum[8];
		f[core_pkg::sreg_h] = ({1'b0, a[3:0]} + b[3:0] + cin) > 5'd15;
		return {f, sum[7:0]};
	endfunction

	function automatic logic [15:0] sub_model(input logic [7:0] a, input logic [7:0] b,
		input logic [7:0] s);
		logic [7:0] r;
		logic [7:0] f;
		r = a - b;
		f = nzvs(s, r, (a[7] != b[7]) && (r[7] != a[7]));
		f[core_pkg::sreg_c] = a < b;
		f[core_pkg::sreg_h] = a[3:0] < b[3:0];   // Borrow out of the low nibble
		return {f, r};
	endfunction

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic clear_rom();
		for (int i = 0; i < 4096; i++)
			rom[i] = 16'h0000;
		plen = 0;
	endtask

	task automatic put(input logic [15:0] w);
		rom[plen] = w;
		plen++;
	endtask

	task automatic reset_core();
		@(posedge ALU_CLK);
		hclk <= 1'b1;
		repeat (16) @(posedge ALU_CLK);
		hclk <= 1'b0;
		wr_addr_q.delete();
		wr_data_q.delete();
		rd_cnt = 0;
		@(negedge ALU_CLK);   // Middle of the first fetch
	endtask

	// One instruction is one fetch cycle and one execute cycle
	task automatic step(input int n);
		repeat (2 * n) @(posedge ALU_CLK);
		@(negedge ALU_CLK);
	endtask

	task automatic expect_write(input logic [5:0] addr, input logic [7:0] data);
		if (wr_addr_q.size() == 0)
		begin
			errors++;
			$display("No IO write strobe was seen for port %h", addr);
		end
		else
		begin
			compare("o_io.addr", wr_addr_q.pop_front(), addr);
			compare("o_io.dout", wr_data_q.pop_front(), data);
		end
	endtask

	// Executes the op, then the OUT of its destination
	task automatic op_check(input logic [15:0] res, input logic [5:0] addr);
		step(1);
		compare("o_sreg", sreg, res[15:8]);
		step(1);
		expect_write(addr, res[7:0]);
	endtask

	task automatic flow_check(input logic [11:0] exp_pc, input logic [7:0] exp_s);
		step(1);
		compare("o_pc", pc, exp_pc);
		compare("o_sreg", sreg, exp_s);
	endtask

	task automatic test_done(input string name, input int err0);
		tests++;
		$display("%s finished with %0d errors", name, errors - err0);
	endtask

	task automatic reset_nop_test();
		int err0;
		err0 = errors;
		clear_rom();
		reset_core();
		compare("o_pc", pc, 16'h0000);
		compare("o_sreg", sreg, 16'h0000);
		compare("o_io.wr", io.wr, 16'h0000);
		compare("o_io.rd", io.rd, 16'h0000);
		for (int k = 1; k <= 4; k++)
		begin
			step(1);
			compare("o_pc", pc, k);
		end
		test_done("reset and NOP", err0);
	endtask

	task automatic arith_test();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] res;
		int          err0;
		err0 = errors;
		a = 8'($random(seed));
		b = 8'($random(seed));
		clear_rom();
		put(ldi_word(4'd0, a));
		put(ldi_word(4'd1, b));
		put(pair_word(6'b000011, 5'd16, 5'd17));   // ADD
		put(port_word(1'b1, 6'h01, 5'd16));
		put(pair_word(6'b000111, 5'd16, 5'd17));   // ADC
		put(port_word(1'b1, 6'h02, 5'd16));
		put(pair_word(6'b000110, 5'd16, 5'd17));   // SUB
		put(port_word(1'b1, 6'h03, 5'd16));
		put(pair_word(6'b000101, 5'd16, 5'd17));   // CP
		put(port_word(1'b1, 6'h04, 5'd16));
		reset_core();
		step(2);
		res = add_model(a, b, 1'b0, 8'h00);
		op_check(res, 6'h01);
		res = add_model(res[7:0], b, res[8 + core_pkg::sreg_c], res[15:8]);
		op_check(res, 6'h02);
		res = sub_model(res[7:0], b, res[15:8]);
		op_check(res, 6'h03);
		a = res[7:0];
		res = sub_model(a, b, res[15:8]);
		op_check({res[15:8], a}, 6'h04);   // CP keeps r16
		test_done("arithmetic", err0);
	endtask

	task automatic logic_test();
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] z;
		logic [7:0] acc;
		logic [7:0] s;
		int         err0;
		err0 = errors;
		x = 8'($random(seed));
		y = 8'($random(seed));
		z = 8'($random(seed));
		clear_rom();
		put(ldi_word(4'd2, x));
		put(ldi_word(4'd3, y));
		put(ldi_word(4'd4, z));
		put(pair_word(6'b001000, 5'd18, 5'd19));   // AND
		put(port_word(1'b1, 6'h05, 5'd18));
		put(pair_word(6'b001010, 5'd18, 5'd20));   // OR
		put(port_word(1'b1, 6'h06, 5'd18));
		put(pair_word(6'b001001, 5'd18, 5'd19));   // EOR
		put(port_word(1'b1, 6'h07, 5'd18));
		put(pair_word(6'b001011, 5'd21, 5'd19));   // MOV
		put(port_word(1'b1, 6'h08, 5'd21));
		put(ldi_word(4'd6, 8'h7F));
		put(single_word(5'd22, 4'b0011));          // INC
		put(port_word(1'b1, 6'h09, 5'd22));
		put(ldi_word(4'd7, 8'h80));
		put(single_word(5'd23, 4'b1010));          // DEC
		put(port_word(1'b1, 6'h0A, 5'd23));
		put(single_word(5'd18, 4'b0110));          // LSR
		put(port_word(1'b1, 6'h0B, 5'd18));
		put(single_word(5'd19, 4'b0010));          // SWAP
		put(port_word(1'b1, 6'h0C, 5'd19));
		reset_core();
		step(3);
		acc = x & y;
		s = nzvs(8'h00, acc, 1'b0);
		op_check({s, acc}, 6'h05);
		acc = acc | z;
		s = nzvs(s, acc, 1'b0);
		op_check({s, acc}, 6'h06);
		acc = acc ^ y;
		s = nzvs(s, acc, 1'b0);
		op_check({s, acc}, 6'h07);
		op_check({s, y}, 6'h08);
		step(1);
		s = nzvs(s, 8'h80, 1'b1);
		op_check({s, 8'h80}, 6'h09);
		step(1);
		s = nzvs(s, 8'h7F, 1'b1);
		op_check({s, 8'h7F}, 6'h0A);
		s = nzvs(s, {1'b0, acc[7:1]}, acc[0]);   // V is N xor C with N clear
		s[core_pkg::sreg_c] = acc[0];
		op_check({s, 1'b0, acc[7:1]}, 6'h0B);
		op_check({s, y[3:0], y[7:4]}, 6'h0C);
		test_done("logic", err0);
	endtask

	task automatic flow_test();
		int err0;
		err0 = errors;
		clear_rom();
		rom[0]  = flag_word(1'b0, 3'd6);
		rom[1]  = flag_word(1'b0, 3'd0);
		rom[2]  = flag_word(1'b1, 3'd6);
		rom[3]  = {4'b1100, 12'd3};                   // RJMP forward
		rom[4]  = branch_word(1'b0, 7'd3, 3'd1);      // BRBS Z untaken
		rom[5]  = branch_word(1'b1, 7'h7A, 3'd1);     // BRBC Z taken back
		rom[7]  = branch_word(1'b0, 7'd2, 3'd0);      // BRBS C taken
		rom[10] = branch_word(1'b1, 7'd5, 3'd0);      // BRBC C untaken
		rom[11] = {4'b1100, 12'hFF8};                 // RJMP backward
		reset_core();
		flow_check(next_pc(12'd0, 12'd0), 8'h40);
		flow_check(next_pc(12'd1, 12'd0), 8'h41);
		flow_check(next_pc(12'd2, 12'd0), 8'h01);
		flow_check(next_pc(12'd3, 12'd3), 8'h01);
		flow_check(next_pc(12'd7, 12'd2), 8'h01);
		flow_check(next_pc(12'd10, 12'd0), 8'h01);
		flow_check(next_pc(12'd11, 12'hFF8), 8'h01);
		flow_check(next_pc(12'd4, 12'd0), 8'h01);
		flow_check(next_pc(12'd5, 12'hFFA), 8'h01);
		test_done("control flow", err0);
	endtask

	task automatic io_test();
		logic [7:0] din;
		int         err0;
		err0 = errors;
		din = 8'($random(seed));
		clear_rom();
		put(port_word(1'b0, 6'h2A, 5'd24));   // IN
		put(port_word(1'b1, 6'h15, 5'd24));
		@(posedge ALU_CLK);
		io_din <= din;
		reset_core();
		step(1);
		compare("o_io.rd count", rd_cnt, 16'd1);
		compare("o_io.addr", rd_addr, 16'h002A);
		compare("o_sreg", sreg, 16'h0000);
		step(1);
		expect_write(6'h15, din);
		compare("o_io.wr count", wr_addr_q.size(), 16'd0);
		test_done("IO", err0);
	endtask

	initial
	begin
		seed    = 84457;
		hclk    = 1'b1;
		io_din  = 8'h00;
		errors  = 0;
		checks  = 0;
		tests   = 0;
		rd_cnt  = 0;
		wr_prev = 1'b0;
		rd_prev = 1'b0;
		clear_rom();
		reset_nop_test();
		arith_test();
		logic_test();
		flow_test();
		io_test();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		#(limit_ns);
		$display("Timeout, the tests did not finish within %0d ns", limit_ns);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- core_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_top (
	input  wire                          ALU_CLK,
	input  wire                          hclk,
	input  wire  [15:0]                  i_opcode,
	input  wire  [core_pkg::data_w-1:0]  i_io_din,
	output logic [core_pkg::pc_w-1:0]    o_pc,
	output core_pkg::io_bus_t            o_io,
	output logic [core_pkg::data_w-1:0]  o_sreg
);

	core_pkg::instr_t              instr;
	logic [15:0]                   ir;
	logic                          phase_exec;
	logic                          branch_taken;
	logic [core_pkg::data_w-1:0]   rd_data;
	logic [core_pkg::data_w-1:0]   rr_data;
	logic [core_pkg::data_w-1:0]   alu_result;

	cycle_sequencer cycle_sequencer_i (
		.ALU_CLK      (ALU_CLK),
		.hclk         (hclk),
		.i_opcode     (i_opcode),
		.i_instr      (instr),
		.i_rd_data    (rd_data),
		.o_ir         (ir),
		.o_phase_exec (phase_exec),
		.o_io         (o_io)
	);

	program_counter program_counter_i (
		.ALU_CLK        (ALU_CLK),
		.hclk           (hclk),
		.i_phase_exec   (phase_exec),
		.i_instr        (instr),
		.i_branch_taken (branch_taken),
		.o_pc           (o_pc)
	);

	opcode_decoder opcode_decoder_i (
		.i_ir    (ir),
		.o_instr (instr)
	);

	register_file register_file_i (
		.ALU_CLK      (ALU_CLK),
		.hclk         (hclk),
		.i_phase_exec (phase_exec),
		.i_instr      (instr),
		.i_alu_result (alu_result),
		.i_io_din     (i_io_din),
		.o_rd_data    (rd_data),
		.o_rr_data    (rr_data)
	);

	alu alu_i (
		.ALU_CLK        (ALU_CLK),
		.hclk           (hclk),
		.i_phase_exec   (phase_exec),
		.i_instr        (instr),
		.i_rd_data      (rd_data),
		.i_rr_data      (rr_data),
		.o_result       (alu_result),
		.o_sreg         (o_sreg),
		.o_branch_taken (branch_taken)
	);

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  wire                          ALU_CLK,
	input  wire                          hclk,
	input  wire                          i_phase_exec,
	input  core_pkg::instr_t             i_instr,
	input  wire  [core_pkg::data_w-1:0]  i_rd_data,
	input  wire  [core_pkg::data_w-1:0]  i_rr_data,
	output logic [core_pkg::data_w-1:0]  o_result,
	output logic [core_pkg::data_w-1:0]  o_sreg,
	output logic                         o_branch_taken
);

	logic [core_pkg::data_w-1:0] sreg_d;
	logic [core_pkg::data_w-1:0] a;
	logic [core_pkg::data_w-1:0] b;
	logic [core_pkg::data_w-1:0] r;

	assign a        = i_rd_data;
	assign b        = i_rr_data;
	assign o_result = r;

	always_comb
	begin
		r      = a;
		sreg_d = o_sreg;
		case (i_instr.op)
			core_pkg::OP_ADD, core_pkg::OP_ADC:
			begin
				r = a + b + ((i_instr.op == core_pkg::OP_ADC) ? o_sreg[core_pkg::sreg_c] : 1'b0);
				sreg_d[core_pkg::sreg_h] = (a[3] & b[3]) | (b[3] & ~r[3]) | (~r[3] & a[3]);
				sreg_d[core_pkg::sreg_v] = (a[7] & b[7] & ~r[7]) | (~a[7] & ~b[7] & r[7]);
				sreg_d[core_pkg::sreg_c] = (a[7] & b[7]) | (b[7] & ~r[7]) | (~r[7] & a[7]);
			end
			core_pkg::OP_SUB, core_pkg::OP_CP:
			begin
				r = a - b;
				// Borrow form of the carry equations
				sreg_d[core_pkg::sreg_h] = (~a[3] & b[3]) | (b[3] & r[3]) | (r[3] & ~a[3]);
				sreg_d[core_pkg::sreg_v] = (a[7] & ~b[7] & ~r[7]) | (~a[7] & b[7] & r[7]);
				sreg_d[core_pkg::sreg_c] = (~a[7] & b[7]) | (b[7] & r[7]) | (r[7] & ~a[7]);
			end
			core_pkg::OP_AND, core_pkg::OP_OR, core_pkg::OP_EOR:
			begin
				if (i_instr.op == core_pkg::OP_AND)
					r = a & b;
				else if (i_instr.op == core_pkg::OP_OR)
					r = a | b;
				else
					r = a ^ b;
				sreg_d[core_pkg::sreg_v] = 1'b0;
			end
			core_pkg::OP_INC:
			begin
				r = a + 1'b1;
				sreg_d[core_pkg::sreg_v] = (r == 8'h80);
			end
			core_pkg::OP_DEC:
			begin
				r = a - 1'b1;
				sreg_d[core_pkg::sreg_v] = (r == 8'h7F);
			end
			core_pkg::OP_LSR:
			begin
				r = {1'b0, a[7:1]};
				sreg_d[core_pkg::sreg_c] = a[0];
				sreg_d[core_pkg::sreg_v] = a[0];   // N is 0 here
			end
			core_pkg::OP_SWAP: r = {a[3:0], a[7:4]};
			core_pkg::OP_BSET: sreg_d[i_instr.bit_sel] = i_instr.bit_val;
			default: r = a;
		endcase

		// Common N, Z and S update
		case (i_instr.op)
			core_pkg::OP_ADD, core_pkg::OP_ADC, core_pkg::OP_SUB, core_pkg::OP_CP,
			core_pkg::OP_AND, core_pkg::OP_OR, core_pkg::OP_EOR,
			core_pkg::OP_INC, core_pkg::OP_DEC, core_pkg::OP_LSR:
			begin
				sreg_d[core_pkg::sreg_n] = r[7];
				sreg_d[core_pkg::sreg_z] = (r == '0);
				sreg_d[core_pkg::sreg_s] = r[7] ^ sreg_d[core_pkg::sreg_v];
			end
			default: ;
		endcase
	end

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
			o_sreg <= '0;
		else if (i_phase_exec)
			o_sreg <= sreg_d;
	end

	assign o_branch_taken = (i_instr.op == core_pkg::OP_BRBSC) &&
		(o_sreg[i_instr.bit_sel] == i_instr.bit_val);

	// Flags hold outside execute and for ops that leave them alone
	a_sreg_exec_only: assert property (@(posedge ALU_CLK) disable iff (hclk)
		(!i_phase_exec || (i_instr.op inside {core_pkg::OP_NOP, core_pkg::OP_LDI,
			core_pkg::OP_MOV, core_pkg::OP_SWAP, core_pkg::OP_RJMP, core_pkg::OP_BRBSC,
			core_pkg::OP_IN, core_pkg::OP_OUT, core_pkg::OP_ILLEGAL}))
		|=> $stable(o_sreg));

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  wire                          ALU_CLK,
	input  wire                          hclk,
	input  wire                          i_phase_exec,
	input  core_pkg::instr_t             i_instr,
	input  wire  [core_pkg::data_w-1:0]  i_alu_result,
	input  wire  [core_pkg::data_w-1:0]  i_io_din,
	output logic [core_pkg::data_w-1:0]  o_rd_data,
	output logic [core_pkg::data_w-1:0]  o_rr_data
);

	logic [core_pkg::data_w-1:0] regs [32];
	logic [core_pkg::data_w-1:0] wr_data;

	assign o_rd_data = regs[i_instr.rd];
	assign o_rr_data = regs[i_instr.rr];

	always_comb
	begin
		case (i_instr.op)
			core_pkg::OP_LDI: wr_data = i_instr.imm;
			core_pkg::OP_MOV: wr_data = o_rr_data;
			core_pkg::OP_IN:  wr_data = i_io_din;   // Device answers within the cycle
			default:          wr_data = i_alu_result;
		endcase
	end

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (i_phase_exec && i_instr.wr_rd)
			regs[i_instr.rd] <= wr_data;
	end

endmodule

`default_nettype wire

//--- program_counter.sv
`timescale 1ns/1ns
`default_nettype none

module program_counter (
	input  wire                        ALU_CLK,
	input  wire                        hclk,
	input  wire                        i_phase_exec,
	input  core_pkg::instr_t           i_instr,
	input  wire                        i_branch_taken,
	output logic [core_pkg::pc_w-1:0]  o_pc
);

	logic [core_pkg::pc_w-1:0] pc_inc;
	logic                      take_offset;

	assign pc_inc      = o_pc + 1'b1;
	assign take_offset = (i_instr.op == core_pkg::OP_RJMP) || i_branch_taken;

	// Wraps modulo 4096
	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
			o_pc <= '0;
		else if (i_phase_exec)
		begin
			if (take_offset)
				o_pc <= pc_inc + i_instr.offset;
			else
				o_pc <= pc_inc;
		end
	end

endmodule

`default_nettype wire

//--- cycle_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cycle_sequencer (
	input  wire                          ALU_CLK,
	input  wire                          hclk,
	input  wire  [15:0]                  i_opcode,
	input  core_pkg::instr_t             i_instr,
	input  wire  [core_pkg::data_w-1:0]  i_rd_data,
	output logic [15:0]                  o_ir,
	output logic                         o_phase_exec,
	output core_pkg::io_bus_t            o_io
);

	core_pkg::phase_t phase_q;

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			phase_q <= core_pkg::PH_FETCH;
			o_ir    <= '0;   // Decodes as NOP
		end
		else
		begin
			phase_q <= (phase_q == core_pkg::PH_FETCH) ? core_pkg::PH_EXEC : core_pkg::PH_FETCH;
			if (phase_q == core_pkg::PH_FETCH)
				o_ir <= i_opcode;
		end
	end

	assign o_phase_exec = (phase_q == core_pkg::PH_EXEC);

	// Port strobes live for the execute cycle only
	assign o_io.wr   = o_phase_exec && (i_instr.op == core_pkg::OP_OUT);
	assign o_io.rd   = o_phase_exec && (i_instr.op == core_pkg::OP_IN);
	assign o_io.addr = i_instr.io_addr;
	assign o_io.dout = i_rd_data;

	// Strobes only from an IN or OUT word held in the IR
	a_strobe_phase: assert property (@(posedge ALU_CLK) disable iff (hclk)
		(o_io.wr || o_io.rd) |-> (o_phase_exec && !(o_io.wr && o_io.rd)
			&& (o_ir[15:12] == 4'b1011) && (o_ir[11] == o_io.wr)));

endmodule

`default_nettype wire

//--- opcode_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module opcode_decoder (
	input  wire  [15:0]       i_ir,
	output core_pkg::instr_t  o_instr
);

	always_comb
	begin
		o_instr.op      = core_pkg::OP_ILLEGAL;
		o_instr.rd      = i_ir[8:4];
		o_instr.rr      = {i_ir[9], i_ir[3:0]};
		o_instr.imm     = {i_ir[11:8], i_ir[3:0]};
		o_instr.bit_sel = i_ir[2:0];
		o_instr.bit_val = ~i_ir[10];                    // BRBS when 0
		o_instr.offset  = {{5{i_ir[9]}}, i_ir[9:3]};    // Branch k7
		o_instr.io_addr = {i_ir[10:9], i_ir[3:0]};
		o_instr.wr_rd   = 1'b0;

		casez (i_ir)
			16'b0000_0000_0000_0000: o_instr.op = core_pkg::OP_NOP;
			16'b0000_11??_????_????: o_instr.op = core_pkg::OP_ADD;
			16'b0001_11??_????_????: o_instr.op = core_pkg::OP_ADC;
			16'b0001_10??_????_????: o_instr.op = core_pkg::OP_SUB;
			16'b0001_01??_????_????: o_instr.op = core_pkg::OP_CP;
			16'b0010_00??_????_????: o_instr.op = core_pkg::OP_AND;
			16'b0010_10??_????_????: o_instr.op = core_pkg::OP_OR;
			16'b0010_01??_????_????: o_instr.op = core_pkg::OP_EOR;
			16'b0010_11??_????_????: o_instr.op = core_pkg::OP_MOV;
			16'b1001_010?_????_0011: o_instr.op = core_pkg::OP_INC;
			16'b1001_010?_????_1010: o_instr.op = core_pkg::OP_DEC;
			16'b1001_010?_????_0110: o_instr.op = core_pkg::OP_LSR;
			16'b1001_010?_????_0010: o_instr.op = core_pkg::OP_SWAP;
			16'b1011_0???_????_????: o_instr.op = core_pkg::OP_IN;
			16'b1011_1???_????_????: o_instr.op = core_pkg::OP_OUT;
			16'b1111_0???_????_????: o_instr.op = core_pkg::OP_BRBSC;
			16'b1110_????_????_????:
			begin
				o_instr.op = core_pkg::OP_LDI;
				o_instr.rd = {1'b1, i_ir[7:4]};   // r16 to r31 only
			end
			16'b1001_0100_????_1000:
			begin
				o_instr.op      = core_pkg::OP_BSET;
				o_instr.bit_sel = i_ir[6:4];
				o_instr.bit_val = ~i_ir[7];       // BCLR has bit 7 set
			end
			16'b1100_????_????_????:
			begin
				o_instr.op     = core_pkg::OP_RJMP;
				o_instr.offset = i_ir[11:0];
			end
			default: o_instr.op = core_pkg::OP_ILLEGAL;
		endcase

		// CP touches only the flags
		case (o_instr.op)
			core_pkg::OP_ADD, core_pkg::OP_ADC, core_pkg::OP_SUB,
			core_pkg::OP_AND, core_pkg::OP_OR, core_pkg::OP_EOR,
			core_pkg::OP_INC, core_pkg::OP_DEC, core_pkg::OP_LSR,
			core_pkg::OP_SWAP, core_pkg::OP_LDI, core_pkg::OP_MOV,
			core_pkg::OP_IN:
				o_instr.wr_rd = 1'b1;
			default:
				o_instr.wr_rd = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int pc_w       = 12;
	localparam int reg_addr_w = 5;
	localparam int data_w     = 8;
	localparam int io_addr_w  = 6;

	// Status register bits
	localparam int sreg_c = 0;
	localparam int sreg_z = 1;
	localparam int sreg_n = 2;
	localparam int sreg_v = 3;
	localparam int sreg_s = 4;
	localparam int sreg_h = 5;
	localparam int sreg_t = 6;
	localparam int sreg_i = 7;

	typedef enum logic {
		PH_FETCH,
		PH_EXEC
	} phase_t;

	typedef enum logic [4:0] {
		OP_NOP,
		OP_LDI,
		OP_MOV,
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_CP,
		OP_AND,
		OP_OR,
		OP_EOR,
		OP_INC,
		OP_DEC,
		OP_LSR,
		OP_SWAP,
		OP_BSET,     // BSET and BCLR
		OP_RJMP,
		OP_BRBSC,    // BRBS and BRBC
		OP_IN,
		OP_OUT,
		OP_ILLEGAL
	} opcode_t;

	typedef struct packed {
		opcode_t                 op;
		logic [reg_addr_w-1:0]   rd;
		logic [reg_addr_w-1:0]   rr;
		logic [data_w-1:0]       imm;
		logic [2:0]              bit_sel;
		logic                    bit_val;  // Set/clear, or branch-if-set
		logic [pc_w-1:0]         offset;   // Already sign-extended
		logic [io_addr_w-1:0]    io_addr;
		logic                    wr_rd;
	} instr_t;

	typedef struct packed {
		logic [io_addr_w-1:0] addr;
		logic [data_w-1:0]    dout;
		logic                 wr;
		logic                 rd;
	} io_bus_t;

endpackage

`default_nettype wire
